// ==== Bender.yml ====
package:
  name: ritc_full_datapath

sources:
  - ritc_pkg.sv
  - ritc_input_buffers.sv
  - ritc_lane_delay.sv
  - ritc_lane_deserializer.sv
  - ritc_dual_datapath.sv
  - ritc_full_datapath.sv
  - target: test
    files:
      - ritc_checker.sv
      - tb_ritc_full_datapath.sv

// ==== ritc_checker.sv ====
`timescale 1ns/1ps
module ritc_checker #(
	parameter int NUM_CH = 6
) (
	input  logic                                     user_clk_i,
	input  logic                                     rst_i,
	input  logic [NUM_CH*ritc_pkg::LANES_PER_CH-1:0] ser_lane_i,
	input  logic                                     sync_i,
	input  logic                                     user_sel_i,
	input  logic [3:0]                               user_addr_i,
	input  logic                                     user_wr_i,
	input  logic                                     user_rd_i,
	input  logic [31:0]                              user_dat_i,
	input  logic [NUM_CH*ritc_pkg::WORD_W-1:0]       ch_word_o,
	input  logic [NUM_CH-1:0]                        ch_valid_o,
	input  logic [NUM_CH*ritc_pkg::LANES_PER_CH-1:0] lane_bypass_o,
	input  logic [31:0]                              user_dat_o,
	input  int                                       test_num_i,
	output int                                       err_cnt_o = 0,
	output int                                       chk_cnt_o = 0
);
	import ritc_pkg::*;

	localparam int NL = NUM_CH * LANES_PER_CH;

	//////////////////////////////////////////////////////////////
	// Reference model state.
	//////////////////////////////////////////////////////////////

	// Buffered lanes. Entry k is k cycles old.
	logic [NL-1:0]           hist [0:MAX_DELAY];
	// Entries older than hist[0] that survived the last reset.
	int                      fresh;
	// Last four bits into each deserializer. Entry 0 is newest.
	logic [LANES_PER_CH-1:0] ent [NUM_CH][DESER_RATIO];
	logic [WORD_W-1:0]       exp_word [NUM_CH];
	logic [NUM_CH-1:0]       exp_valid;
	logic [NUM_CH-1:0]       run;
	logic [NUM_CH-1:0]       slip_pend;
	int                      next_valid [NUM_CH];
	logic [NL-1:0]           exp_bypass;
	logic [31:0]             exp_rd;
	// Register shadows taken from the bus.
	logic                    dis = 1'b1;
	logic                    dp_pend = 1'b0;
	logic [7:0]              slip_mask = '0;
	logic [DELAY_W-1:0]      dly_val = '0;
	logic [2:0]              sel_ch = '0;
	logic [DELAY_W-1:0]      dly [NUM_CH] = '{default: '0};
	logic                    armed = 1'b0;
	int                      cyc = 0;
	int                      test_prev = 0;
	int                      err_start = 0;
	int                      chk_start = 0;

	function automatic string test_name(input int n);
		case (n)
			1: return "reset defaults";
			2: return "enable and framing";
			3: return "random delays";
			4: return "bitslip";
			5: return "register readback";
			6: return "datapath reset";
			default: return "unknown";
		endcase
	endfunction

	// Expected register value from the map.
	function automatic logic [31:0] readback(input logic [3:0] a);
		ritc_reg_word_u r;
		r.raw = '0;
		case (a)
			REG_CTRL: r.ctrl.dis = dis;
			REG_SLIP: r.slip.ch_mask = slip_mask;
			REG_DELAY_VAL: r.dly.value = dly_val;
			REG_DELAY_LOAD: begin
				r.dly.ch = sel_ch;
				if (int'(sel_ch) < NUM_CH) r.dly.value = dly[sel_ch];
			end
			default: r.raw = '0;
		endcase
		return r.raw;
	endfunction

	task automatic compare(input string what, input int ch, input logic [127:0] got,
		input logic [127:0] exp);
		chk_cnt_o++;
		if (got !== exp) begin
			err_cnt_o++;
			$display("CHECK FAILED at time %0t: %s ch %0d got %h expected %h",
				$time, what, ch, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////
	// Compare last cycle, then step the model by one edge.
	//////////////////////////////////////////////////////////////

	always @(posedge user_clk_i) begin
		logic [LANES_PER_CH-1:0] din [NUM_CH];
		logic [NL-1:0]           b_now;
		ritc_reg_word_u          w;
		logic                    dp;
		logic                    wr_ok;
		if (armed) begin
			compare("lane_bypass_o", 0, lane_bypass_o, exp_bypass);
			compare("user_dat_o", 0, user_dat_o, exp_rd);
			for (int c = 0; c < NUM_CH; c++) begin
				compare("ch_valid_o", c, ch_valid_o[c], exp_valid[c]);
				compare("ch_word_o", c, ch_word_o[c*WORD_W +: WORD_W], exp_word[c]);
			end
		end
		if (test_num_i != test_prev) begin
			if (test_prev > 0) begin
				$display("test %0d %s finished: %0d checks, %0d errors", test_prev,
					test_name(test_prev), chk_cnt_o - chk_start, err_cnt_o - err_start);
			end
			test_prev = test_num_i;
			chk_start = chk_cnt_o;
			err_start = err_cnt_o;
		end
		w.raw = user_dat_i;
		wr_ok = user_sel_i && user_wr_i;
		dp = rst_i || dp_pend;
		// Delay line output seen during the cycle just ended.
		for (int c = 0; c < NUM_CH; c++) begin
			if (int'(dly[c]) <= fresh) din[c] = hist[dly[c]][c*LANES_PER_CH +: LANES_PER_CH];
			else din[c] = '0;
		end
		// Input buffer gated by the old disable bit.
		b_now = (rst_i || dis) ? '0 : ser_lane_i;
		for (int k = MAX_DELAY; k > 0; k--) begin
			hist[k] = hist[k-1];
		end
		hist[0] = b_now;
		exp_bypass = b_now;
		if (dp) fresh = 0;
		else if (fresh < MAX_DELAY) fresh++;
		// Valid comes four edges after sync.
		// A slip adds one edge.
		for (int c = 0; c < NUM_CH; c++) begin
			exp_valid[c] = 1'b0;
			if (dp) begin
				for (int b = 0; b < DESER_RATIO; b++) ent[c][b] = '0;
				exp_word[c] = '0;
				run[c] = 1'b0;
			end else begin
				for (int b = DESER_RATIO - 1; b > 0; b--) ent[c][b] = ent[c][b-1];
				ent[c][0] = din[c];
				if (sync_i) begin
					run[c] = 1'b1;
					next_valid[c] = cyc + DESER_RATIO;
				end else if (run[c]) begin
					if (slip_pend[c]) begin
						next_valid[c]++;
					end else if (cyc == next_valid[c]) begin
						exp_valid[c] = 1'b1;
						next_valid[c] = cyc + DESER_RATIO;
						for (int l = 0; l < LANES_PER_CH; l++) begin
							for (int b = 0; b < DESER_RATIO; b++) begin
								exp_word[c][l*DESER_RATIO+b] = ent[c][b][l];
							end
						end
					end
				end
			end
		end
		// Bus side. Reads see the registers before this edge's write.
		if (rst_i) begin
			exp_rd = '0;
			dis = 1'b1;
			dp_pend = 1'b0;
		end else begin
			if (user_sel_i && user_rd_i) exp_rd = readback(user_addr_i);
			dp_pend = wr_ok && (user_addr_i == REG_CTRL) && w.ctrl.dp_reset;
			if (wr_ok && (user_addr_i == REG_CTRL)) dis = w.ctrl.dis;
		end
		slip_pend = '0;
		if (wr_ok && (user_addr_i == REG_SLIP)) begin
			slip_mask = w.slip.ch_mask;
			if (!dp) slip_pend = w.slip.ch_mask[NUM_CH-1:0];
		end
		if (wr_ok && (user_addr_i == REG_DELAY_LOAD)) begin
			sel_ch = w.dly.ch;
			if (int'(w.dly.ch) < NUM_CH) dly[w.dly.ch] = dly_val;
		end
		if (wr_ok && (user_addr_i == REG_DELAY_VAL)) dly_val = w.dly.value;
		if (rst_i) armed = 1'b1;
		cyc++;
	end

endmodule

// ==== ritc_dual_datapath.sv ====
`timescale 1ns/1ps
module ritc_dual_datapath #(
	parameter int NUM_CH = 6
) (
	input  logic                                  user_clk_i,
	input  logic                                  rst_i,
	input  logic                                  sync_i,
	input  logic [NUM_CH*ritc_pkg::LANES_PER_CH-1:0] lane_i,
	input  logic                                  user_sel_i,
	input  logic [3:0]                            user_addr_i,
	input  logic                                  user_wr_i,
	input  logic                                  user_rd_i,
	input  logic [31:0]                           user_dat_i,
	output logic [31:0]                           reg_rd_o,
	output logic [NUM_CH*ritc_pkg::WORD_W-1:0]    ch_word_o,
	output logic [NUM_CH-1:0]                     ch_valid_o
);
	import ritc_pkg::*;

	//////////////////////////////////////////////////////////////
	// Register writes.
	//////////////////////////////////////////////////////////////

	ritc_reg_word_u wr_word;
	ritc_reg_word_u rd_word;
	assign wr_word = user_dat_i;

	logic wr_slip;
	logic wr_val;
	logic wr_load;
	assign wr_slip = user_sel_i && user_wr_i && (user_addr_i == REG_SLIP);
	assign wr_val  = user_sel_i && user_wr_i && (user_addr_i == REG_DELAY_VAL);
	assign wr_load = user_sel_i && user_wr_i && (user_addr_i == REG_DELAY_LOAD);

	// Last slip mask, staged delay and loaded delays.
	logic [7:0]         slip_mask = '0;
	logic [DELAY_W-1:0] delay_val = '0;
	logic [2:0]         sel_ch = '0;
	logic [DELAY_W-1:0] ch_delay [NUM_CH] = '{default: '0};
	// One-cycle slip strobe per channel.
	logic [NUM_CH-1:0]  slip_pulse;

	always_ff @(posedge user_clk_i) begin
		if (wr_slip) slip_mask <= wr_word.slip.ch_mask;
		if (wr_val) delay_val <= wr_word.dly.value;
		if (wr_load) begin
			sel_ch <= wr_word.dly.ch;
			// Out-of-range channel index loads nothing.
			for (int c = 0; c < NUM_CH; c++) begin
				if (int'(wr_word.dly.ch) == c) ch_delay[c] <= delay_val;
			end
		end
	end

	always_ff @(posedge user_clk_i) begin
		if (rst_i) begin
			slip_pulse <= '0;
		end else begin
			slip_pulse <= wr_slip ? wr_word.slip.ch_mask[NUM_CH-1:0] : '0;
		end
	end

	//////////////////////////////////////////////////////////////
	// Readback of registers 1 to 3.
	//////////////////////////////////////////////////////////////

	// Reads zero outside a read strobe.
	always_comb begin
		rd_word.raw = '0;
		if (user_sel_i && user_rd_i) begin
			case (user_addr_i)
				REG_SLIP:      rd_word.slip.ch_mask = slip_mask;
				REG_DELAY_VAL: rd_word.dly.value = delay_val;
				REG_DELAY_LOAD: begin
					rd_word.dly.ch = sel_ch;
					if (int'(sel_ch) < NUM_CH) rd_word.dly.value = ch_delay[sel_ch];
				end
				default:       rd_word.raw = '0;
			endcase
		end
	end
	assign reg_rd_o = rd_word.raw;

	// Per channel delay line then deserializer.
	for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
		logic [LANES_PER_CH-1:0] lane_dly;
		ritc_lane_delay u_delay (.user_clk_i(user_clk_i), .rst_i(rst_i), .delay_i(ch_delay[c]),
			.lane_i(lane_i[c*LANES_PER_CH +: LANES_PER_CH]), .lane_o(lane_dly));
		ritc_lane_deserializer u_deser (.user_clk_i(user_clk_i), .rst_i(rst_i),
			.sync_i(sync_i), .bitslip_i(slip_pulse[c]), .lane_i(lane_dly),
			.word_o(ch_word_o[c*WORD_W +: WORD_W]), .valid_o(ch_valid_o[c]));
	end

endmodule

// ==== ritc_full_datapath.sv ====
`timescale 1ns/1ps
module ritc_full_datapath #(
	parameter int NUM_CH = 6
) (
	input  logic                                  user_clk_i,
	input  logic                                  rst_i,
	input  logic [NUM_CH*ritc_pkg::LANES_PER_CH-1:0] ser_lane_i,
	input  logic                                  sync_i,
	input  logic                                  user_sel_i,
	input  logic [3:0]                            user_addr_i,
	input  logic                                  user_wr_i,
	input  logic                                  user_rd_i,
	input  logic [31:0]                           user_dat_i,
	output logic [NUM_CH*ritc_pkg::WORD_W-1:0]    ch_word_o,
	output logic [NUM_CH-1:0]                     ch_valid_o,
	output logic [NUM_CH*ritc_pkg::LANES_PER_CH-1:0] lane_bypass_o,
	output logic [31:0]                           user_dat_o
);
	import ritc_pkg::*;

	//////////////////////////////////////////////////////////////
	// Reset/enable register.
	//////////////////////////////////////////////////////////////

	ritc_reg_word_u wr_word;
	ritc_reg_word_u ctrl_word;
	logic           ctrl_wr;
	logic           disable_q;
	logic           datapath_rst;
	logic           dp_rst;
	logic [31:0]    reg_rd;
	logic [NUM_CH*LANES_PER_CH-1:0] buf_lane;

	assign wr_word = user_dat_i;
	assign ctrl_wr = user_sel_i && user_wr_i && (user_addr_i == REG_CTRL);

	// Lanes come up disabled.
	// Reset bit is a strobe, it never stays set.
	always_ff @(posedge user_clk_i) begin
		if (rst_i) begin
			disable_q    <= 1'b1;
			datapath_rst <= 1'b0;
		end else begin
			datapath_rst <= ctrl_wr && wr_word.ctrl.dp_reset;
			if (ctrl_wr) disable_q <= wr_word.ctrl.dis;
		end
	end

	// Delay lines and deserializers also clear on board reset.
	assign dp_rst = rst_i | datapath_rst;

	always_comb begin
		ctrl_word.raw      = '0;
		ctrl_word.ctrl.dis = disable_q;
	end

	// Readback held until the next read.
	always_ff @(posedge user_clk_i) begin
		if (rst_i) begin
			user_dat_o <= '0;
		end else if (user_sel_i && user_rd_i) begin
			user_dat_o <= (user_addr_i == REG_CTRL) ? ctrl_word.raw : reg_rd;
		end
	end

	ritc_input_buffers #(.NUM_CH(NUM_CH)) u_inputs (.user_clk_i(user_clk_i), .rst_i(rst_i),
		.disable_i(disable_q), .lane_i(ser_lane_i), .lane_o(buf_lane),
		.lane_bypass_o(lane_bypass_o));

	ritc_dual_datapath #(.NUM_CH(NUM_CH)) u_datapath (.user_clk_i(user_clk_i), .rst_i(dp_rst),
		.sync_i(sync_i), .lane_i(buf_lane), .user_sel_i(user_sel_i), .user_addr_i(user_addr_i),
		.user_wr_i(user_wr_i), .user_rd_i(user_rd_i), .user_dat_i(user_dat_i),
		.reg_rd_o(reg_rd), .ch_word_o(ch_word_o), .ch_valid_o(ch_valid_o));

endmodule

// ==== ritc_input_buffers.sv ====
`timescale 1ns/1ps
module ritc_input_buffers #(
	parameter int NUM_CH = 6
) (
	input  logic                                  user_clk_i,
	input  logic                                  rst_i,
	input  logic                                  disable_i,
	input  logic [NUM_CH*ritc_pkg::LANES_PER_CH-1:0] lane_i,
	output logic [NUM_CH*ritc_pkg::LANES_PER_CH-1:0] lane_o,
	output logic [NUM_CH*ritc_pkg::LANES_PER_CH-1:0] lane_bypass_o
);
	import ritc_pkg::*;

	// All lanes of the board.
	// Channel c starts at lane 12c.
	localparam int N_LANES = NUM_CH * LANES_PER_CH;

	// Input flop for every lane.
	logic [N_LANES-1:0] lane_q;

	// Stands in for the pad buffer and its IOB flop.
	// Disabled lanes read as zero.
	always_ff @(posedge user_clk_i) begin
		if (rst_i) begin
			lane_q <= '0;
		end else if (disable_i) begin
			lane_q <= '0;
		end else begin
			lane_q <= lane_i;
		end
	end

	// Datapath copy.
	assign lane_o        = lane_q;
	// Bypass copy of the same sample.
	// Leaves the board one cycle after the pins.
	assign lane_bypass_o = lane_q;

endmodule

// ==== ritc_lane_delay.sv ====
`timescale 1ns/1ps
module ritc_lane_delay (
	input  logic                             user_clk_i,
	input  logic                             rst_i,
	input  logic [ritc_pkg::DELAY_W-1:0]      delay_i,
	input  logic [ritc_pkg::LANES_PER_CH-1:0] lane_i,
	output logic [ritc_pkg::LANES_PER_CH-1:0] lane_o
);
	import ritc_pkg::*;

	//////////////////////////////////////////////////////////////
	// Tapped shift register, one column per lane.
	//////////////////////////////////////////////////////////////

	// Stage k holds the lane word from k cycles back.
	logic [LANES_PER_CH-1:0] stage [1:MAX_DELAY];

	// Whole history cleared on datapath reset.
	always_ff @(posedge user_clk_i) begin
		if (rst_i) begin
			for (int k = 1; k <= MAX_DELAY; k++) begin
				stage[k] <= '0;
			end
		end else begin
			stage[1] <= lane_i;
			for (int k = 2; k <= MAX_DELAY; k++) begin
				stage[k] <= stage[k-1];
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// Tap select.
	//////////////////////////////////////////////////////////////

	// Zero delay bypasses the chain.
	// A new delay_i moves the tap at once, history is untouched.
	always_comb begin
		if (delay_i == '0) begin
			lane_o = lane_i;
		end else begin
			lane_o = stage[delay_i];
		end
	end

endmodule

// ==== ritc_lane_deserializer.sv ====
`timescale 1ns/1ps
module ritc_lane_deserializer (
	input  logic                             user_clk_i,
	input  logic                             rst_i,
	input  logic                             sync_i,
	input  logic                             bitslip_i,
	input  logic [ritc_pkg::LANES_PER_CH-1:0] lane_i,
	output logic [ritc_pkg::WORD_W-1:0]       word_o,
	output logic                             valid_o
);
	import ritc_pkg::*;

	// Frame position counter.
	localparam int CNT_W = $clog2(DESER_RATIO);
	localparam logic [CNT_W-1:0] FRAME_LAST = CNT_W'(DESER_RATIO - 1);

	//////////////////////////////////////////////////////////////
	// Per-lane nibble shifters.
	//////////////////////////////////////////////////////////////

	// Lane l sits at bits 4l+3:4l of the flattened array.
	logic [LANES_PER_CH-1:0][DESER_RATIO-1:0] nib;
	logic [LANES_PER_CH-1:0][DESER_RATIO-1:0] nib_next;

	// Newest bit enters at the bottom.
	always_comb begin
		for (int l = 0; l < LANES_PER_CH; l++) begin
			nib_next[l] = {nib[l][DESER_RATIO-2:0], lane_i[l]};
		end
	end

	//////////////////////////////////////////////////////////////
	// Framing.
	//////////////////////////////////////////////////////////////

	logic [CNT_W-1:0] cnt;
	// Framing runs only once a sync has been seen.
	logic             run;

	// Sync restarts the frame, bitslip holds the count one cycle.
	// Word is taken from the next nibbles so the last bit lands too.
	always_ff @(posedge user_clk_i) begin
		if (rst_i) begin
			nib     <= '0;
			cnt     <= '0;
			run     <= 1'b0;
			word_o  <= '0;
			valid_o <= 1'b0;
		end else begin
			nib     <= nib_next;
			valid_o <= 1'b0;
			if (sync_i) begin
				run <= 1'b1;
				cnt <= '0;
			end else if (run && !bitslip_i) begin
				if (cnt == FRAME_LAST) begin
					cnt     <= '0;
					word_o  <= nib_next;
					valid_o <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

endmodule

// ==== ritc_pkg.sv ====
package ritc_pkg;

	//////////////////////////////////////////////////////////////
	// Lane and word geometry.
	//////////////////////////////////////////////////////////////

	// Serial bit lanes per digitizer channel.
	localparam int LANES_PER_CH = 12;
	// Bits gathered per lane for one word.
	localparam int DESER_RATIO  = 4;
	// One deserialized channel word, four bits per lane.
	localparam int WORD_W       = LANES_PER_CH * DESER_RATIO;
	// Delay line tap select.
	localparam int DELAY_W      = 4;
	localparam int MAX_DELAY    = 15;

	//////////////////////////////////////////////////////////////
	// Register map.
	//////////////////////////////////////////////////////////////

	// Reset/enable.
	localparam logic [3:0] REG_CTRL       = 4'h0;
	// Bitslip channel mask.
	localparam logic [3:0] REG_SLIP       = 4'h1;
	// Staged delay value.
	localparam logic [3:0] REG_DELAY_VAL  = 4'h2;
	// Delay load into one channel.
	localparam logic [3:0] REG_DELAY_LOAD = 4'h3;

	// One bus word, decoded by the register it targets.
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [29:0] rsvd;
			logic        dp_reset;
			logic        dis;
		} ctrl;
		struct packed {
			logic [23:0] rsvd;
			logic [7:0]  ch_mask;
		} slip;
		struct packed {
			logic [20:0] rsvd_hi;
			logic [2:0]  ch;
			logic [3:0]  rsvd_lo;
			logic [3:0]  value;
		} dly;
	} ritc_reg_word_u;

endpackage

// ==== sim.f ====
ritc_pkg.sv
ritc_input_buffers.sv
ritc_lane_delay.sv
ritc_lane_deserializer.sv
ritc_dual_datapath.sv
ritc_full_datapath.sv
ritc_checker.sv
tb_ritc_full_datapath.sv

// ==== tb_ritc_full_datapath.sv ====
`timescale 1ns/1ps
module tb_ritc_full_datapath;
	import ritc_pkg::*;

	localparam int NUM_CH     = 6;
	localparam int NL         = NUM_CH * LANES_PER_CH;
	// Cycles any single wait may take.
	localparam int WAIT_LIMIT = 200;

	logic                     user_clk_i = 1'b0;
	logic                     rst_i = 1'b1;
	logic [NL-1:0]            ser_lane_i = '0;
	logic                     sync_i = 1'b0;
	logic                     user_sel_i = 1'b0;
	logic [3:0]               user_addr_i = '0;
	logic                     user_wr_i = 1'b0;
	logic                     user_rd_i = 1'b0;
	logic [31:0]              user_dat_i = '0;
	logic [NUM_CH*WORD_W-1:0] ch_word_o;
	logic [NUM_CH-1:0]        ch_valid_o;
	logic [NL-1:0]            lane_bypass_o;
	logic [31:0]              user_dat_o;
	logic                     lanes_on = 1'b0;
	int                       test_num = 0;
	int                       err_cnt;
	int                       chk_cnt;

	always #4 user_clk_i = ~user_clk_i;

	// Fresh random lane bits every cycle once running.
	always @(negedge user_clk_i) begin
		if (lanes_on) ser_lane_i = NL'({$urandom, $urandom, $urandom});
	end

	ritc_full_datapath #(.NUM_CH(NUM_CH)) dut (.user_clk_i(user_clk_i), .rst_i(rst_i),
		.ser_lane_i(ser_lane_i), .sync_i(sync_i), .user_sel_i(user_sel_i),
		.user_addr_i(user_addr_i), .user_wr_i(user_wr_i), .user_rd_i(user_rd_i),
		.user_dat_i(user_dat_i), .ch_word_o(ch_word_o), .ch_valid_o(ch_valid_o),
		.lane_bypass_o(lane_bypass_o), .user_dat_o(user_dat_o));

	ritc_checker #(.NUM_CH(NUM_CH)) chk (.user_clk_i(user_clk_i), .rst_i(rst_i),
		.ser_lane_i(ser_lane_i), .sync_i(sync_i), .user_sel_i(user_sel_i),
		.user_addr_i(user_addr_i), .user_wr_i(user_wr_i), .user_rd_i(user_rd_i),
		.user_dat_i(user_dat_i), .ch_word_o(ch_word_o), .ch_valid_o(ch_valid_o),
		.lane_bypass_o(lane_bypass_o), .user_dat_o(user_dat_o), .test_num_i(test_num),
		.err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt));

	//////////////////////////////////////////////////////////////
	// Bus and sync helpers driven on the falling edge.
	//////////////////////////////////////////////////////////////

	task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
		@(negedge user_clk_i);
		user_sel_i  = 1'b1;
		user_wr_i   = 1'b1;
		user_addr_i = addr;
		user_dat_i  = data;
		@(negedge user_clk_i);
		user_sel_i = 1'b0;
		user_wr_i  = 1'b0;
	endtask

	// Checker compares the returned word.
	task automatic bus_read(input logic [3:0] addr);
		@(negedge user_clk_i);
		user_sel_i  = 1'b1;
		user_rd_i   = 1'b1;
		user_addr_i = addr;
		@(negedge user_clk_i);
		user_sel_i = 1'b0;
		user_rd_i  = 1'b0;
	endtask

	task automatic pulse_sync();
		@(negedge user_clk_i);
		sync_i = 1'b1;
		@(negedge user_clk_i);
		sync_i = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge user_clk_i);
	endtask

	// Count frames on channel 0.
	task automatic wait_valids(input int n);
		int seen;
		int cycles;
		seen = 0;
		cycles = 0;
		while (seen < n) begin
			@(negedge user_clk_i);
			cycles++;
			if (ch_valid_o[0]) seen++;
			if (cycles > WAIT_LIMIT) begin
				$display("TIMEOUT: channel 0 gave %0d of %0d valid pulses in %0d cycles",
					seen, n, WAIT_LIMIT);
				$display("Simulation FAILED");
				$finish;
			end
		end
	endtask

	initial begin
		// Seed the generator once.
		void'($urandom(32'h740));
		repeat (5) @(posedge user_clk_i);
		lanes_on = 1'b1;
		@(negedge user_clk_i);
		rst_i = 1'b0;
		// Lanes still disabled so frames carry zeros.
		test_num = 1;
		pulse_sync();
		wait_valids(3);
		bus_read(REG_CTRL);
		test_num = 2;
		bus_write(REG_CTRL, 32'h0);
		pulse_sync();
		wait_valids(4);
		test_num = 3;
		repeat (2) begin
			for (int c = 0; c < NUM_CH; c++) begin
				bus_write(REG_DELAY_VAL, $urandom_range(MAX_DELAY, 0));
				bus_write(REG_DELAY_LOAD, c << 8);
			end
			wait_valids(5);
		end
		test_num = 4;
		repeat (4) begin
			bus_write(REG_SLIP, $urandom_range(255, 0));
			wait_valids(3);
		end
		test_num = 5;
		bus_read(REG_SLIP);
		bus_write(REG_DELAY_VAL, $urandom_range(MAX_DELAY, 0));
		bus_read(REG_DELAY_VAL);
		bus_write(REG_DELAY_LOAD, $urandom_range(NUM_CH - 1, 0) << 8);
		bus_read(REG_DELAY_LOAD);
		bus_read(REG_DELAY_VAL);
		// Reset strobe with the lanes left enabled.
		test_num = 6;
		bus_write(REG_CTRL, 32'h2);
		idle(8);
		pulse_sync();
		wait_valids(4);
		bus_read(REG_CTRL);
		bus_read(REG_DELAY_LOAD);
		test_num = 7;
		idle(3);
		$display("All tests done: %0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule
